/* include/fft_defs.svh */
// FFT accelerator widths

`ifndef FFT_DEFS_SVH
`define FFT_DEFS_SVH

// Cache line width in bits.
`define FFT_LINE_W 512

// Complex samples per line.
`define FFT_SAMPLES 16

// Cache-line address width.
`define FFT_ADDR_W 32

// Line FIFO depth, also the bound on reads in flight plus lines held.
`define FFT_FIFO_DEPTH 8

`endif

/* hdl/fft_pkg.sv */
// FFT shared types

`include "fft_defs.svh"

package fft_pkg;

  typedef struct packed {
    logic signed [15:0] re;
    logic signed [15:0] im;
  } t_sample;

  // One cache line, as memory sees it or as samples (sample 0 lowest).
  typedef union packed {
    logic [`FFT_LINE_W-1:0]     raw;
    t_sample [`FFT_SAMPLES-1:0] smp;
  } t_line;

  typedef logic [`FFT_ADDR_W-1:0] t_cl_addr;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_FETCH,
    RD_WAIT,
    RD_FINISH
  } t_rd_state;

  typedef enum logic [2:0] {
    WR_IDLE,
    WR_DATA,
    WR_DRAIN,
    WR_STATUS,
    WR_DONE
  } t_wr_state;

  localparam logic [31:0] HC_CONTROL_START = 32'h0000_0001;

endpackage : fft_pkg

/* hdl/fft_line_fifo.sv */
// Line FIFO with show-ahead head

`timescale 1ns/1ps

`include "fft_defs.svh"

module fft_line_fifo #(
  parameter int DEPTH = `FFT_FIFO_DEPTH
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       enq_en,
  input  fft_pkg::t_line             enq_data,
  input  logic                       deq_en,
  output fft_pkg::t_line             deq_data,
  output logic [$clog2(DEPTH+1)-1:0] count
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [`FFT_LINE_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]       wr_ptr;
  logic [PTR_W-1:0]       rd_ptr;

  // Head is visible before it is dequeued.
  assign deq_data.raw = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (enq_en) begin
      mem[wr_ptr] <= enq_data.raw;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (enq_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (deq_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({enq_en, deq_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    enq_en |-> (count != DEPTH));

  a_no_underflow: assert property (@(posedge clk) disable iff (reset)
    deq_en |-> (count != '0));

endmodule : fft_line_fifo

/* hdl/fft_butterfly.sv */
// Radix-2 butterfly over a line pair

`timescale 1ns/1ps

`include "fft_defs.svh"

module fft_butterfly (
  input  logic           clk,
  input  logic           reset,
  input  logic           pair_start,
  input  fft_pkg::t_line line_in,
  output logic           next_out,
  output fft_pkg::t_line line_out,
  output logic           line_valid
);

  fft_pkg::t_line a_line;
  fft_pkg::t_line sum_line;
  fft_pkg::t_line diff_line;
  logic [1:0]     cap_cnt;
  logic           emit_diff;

  // Line a arrives when cap_cnt is 2, line b when it is 1.
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cap_cnt    <= 2'd0;
      next_out   <= 1'b0;
      emit_diff  <= 1'b0;
      line_valid <= 1'b0;
    end else begin
      if (pair_start) begin
        cap_cnt <= 2'd2;
      end else if (cap_cnt != 2'd0) begin
        cap_cnt <= cap_cnt - 1'b1;
      end
      next_out   <= (cap_cnt == 2'd1);
      emit_diff  <= next_out;
      line_valid <= next_out || emit_diff;
    end
  end

  always_ff @(posedge clk) begin
    if (cap_cnt == 2'd2) begin
      a_line <= line_in;
    end
    // Wrapping 16-bit sums and differences, no scaling.
    if (cap_cnt == 2'd1) begin
      for (int i = 0; i < `FFT_SAMPLES; i++) begin
        sum_line.smp[i].re  <= a_line.smp[i].re + line_in.smp[i].re;
        sum_line.smp[i].im  <= a_line.smp[i].im + line_in.smp[i].im;
        diff_line.smp[i].re <= a_line.smp[i].re - line_in.smp[i].re;
        diff_line.smp[i].im <= a_line.smp[i].im - line_in.smp[i].im;
      end
    end
    if (next_out) begin
      line_out <= sum_line;
    end else if (emit_diff) begin
      line_out <= diff_line;
    end
  end

  a_pair_spacing: assert property (@(posedge clk) disable iff (reset)
    pair_start |-> (cap_cnt == 2'd0));

endmodule : fft_butterfly

/* hdl/fft_requestor.sv */
// FFT memory requestor

`timescale 1ns/1ps

`include "fft_defs.svh"

module fft_requestor (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic [31:0]                            hc_control,
  input  fft_pkg::t_cl_addr                      src_base,
  input  fft_pkg::t_cl_addr                      dst_base,
  input  fft_pkg::t_cl_addr                      dsm_base,
  input  fft_pkg::t_cl_addr                      num_lines,
  output logic                                   rd_req_valid,
  output fft_pkg::t_cl_addr                      rd_req_addr,
  input  logic                                   rd_req_alm_full,
  input  logic                                   rd_rsp_valid,
  input  logic [`FFT_LINE_W-1:0]                 rd_rsp_data,
  output logic                                   wr_req_valid,
  output fft_pkg::t_cl_addr                      wr_req_addr,
  output logic [`FFT_LINE_W-1:0]                 wr_req_data,
  input  logic                                   wr_req_alm_full,
  input  logic                                   wr_rsp_valid,
  output logic                                   in_enq_en,
  output fft_pkg::t_line                         in_enq_data,
  input  fft_pkg::t_line                         in_head,
  input  logic [$clog2(`FFT_FIFO_DEPTH+1)-1:0]   in_count,
  output logic                                   in_deq_en,
  output logic                                   pair_start,
  output fft_pkg::t_line                         pair_line,
  input  fft_pkg::t_line                         out_head,
  input  logic [$clog2(`FFT_FIFO_DEPTH+1)-1:0]   out_count,
  output logic                                   out_deq_en
);

  localparam int CNT_W = $clog2(`FFT_FIFO_DEPTH + 1);

  fft_pkg::t_rd_state rd_state;
  fft_pkg::t_cl_addr  rd_offset;
  logic [CNT_W-1:0]   rd_out;
  logic               rd_room;
  logic               rd_issue;

  logic [1:0]         send_cnt;
  logic [3:0]         bfly_lines;
  logic [4:0]         ps_hist;
  logic               disp_ok;

  fft_pkg::t_wr_state wr_state;
  fft_pkg::t_cl_addr  wr_offset;
  fft_pkg::t_cl_addr  wr_pend;
  logic               st_issue;

  // Reads in flight count until their line lands in in_fifo.
  assign rd_room  = (rd_out + in_count) < `FFT_FIFO_DEPTH;
  assign rd_issue = (rd_state == fft_pkg::RD_FETCH) && rd_room && !rd_req_alm_full;

  // bfly_lines holds result lines not yet visible in out_count.
  assign disp_ok = (send_cnt == 2'd0) && (in_count >= 2) &&
                   ((out_count + bfly_lines + 2) <= `FFT_FIFO_DEPTH);
  assign in_deq_en = (send_cnt != 2'd0);

  assign out_deq_en = (wr_state == fft_pkg::WR_DATA) && (out_count != '0) &&
                      !wr_req_alm_full;
  assign st_issue   = (wr_state == fft_pkg::WR_STATUS) && !wr_req_alm_full;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_state     <= fft_pkg::RD_IDLE;
      rd_offset    <= '0;
      rd_out       <= '0;
      rd_req_valid <= 1'b0;
      in_enq_en    <= 1'b0;
    end else begin
      rd_req_valid <= rd_issue;
      in_enq_en    <= rd_rsp_valid;
      rd_out       <= rd_out + CNT_W'(rd_issue) - CNT_W'(in_enq_en);
      case (rd_state)
        fft_pkg::RD_IDLE: begin
          rd_offset <= '0;
          if (hc_control == fft_pkg::HC_CONTROL_START) begin
            rd_state <= fft_pkg::RD_FETCH;
          end
        end
        fft_pkg::RD_FETCH: begin
          if (rd_issue) begin
            rd_offset <= rd_offset + 1'b1;
            if ((rd_offset + 1'b1) == num_lines) begin
              rd_state <= fft_pkg::RD_FINISH;
            end
          end else if (!rd_room) begin
            rd_state <= fft_pkg::RD_WAIT;
          end
        end
        fft_pkg::RD_WAIT: begin
          if (rd_room) begin
            rd_state <= fft_pkg::RD_FETCH;
          end
        end
        default: begin
          if (hc_control != fft_pkg::HC_CONTROL_START) begin
            rd_state <= fft_pkg::RD_IDLE;
          end
        end
      endcase
    end
  end

  // Pair dispatch: pair_start, then one line per cycle for two cycles.
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      send_cnt   <= 2'd0;
      pair_start <= 1'b0;
      ps_hist    <= '0;
      bfly_lines <= '0;
    end else begin
      pair_start <= disp_ok;
      ps_hist    <= {ps_hist[3:0], pair_start};
      if (disp_ok) begin
        send_cnt <= 2'd2;
      end else if (send_cnt != 2'd0) begin
        send_cnt <= send_cnt - 1'b1;
      end
      // Results enter out_fifo four and five cycles after pair_start.
      bfly_lines <= bfly_lines + {disp_ok, 1'b0} - 4'(ps_hist[3]) - 4'(ps_hist[4]);
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_state     <= fft_pkg::WR_IDLE;
      wr_offset    <= '0;
      wr_pend      <= '0;
      wr_req_valid <= 1'b0;
    end else begin
      wr_req_valid <= out_deq_en || st_issue;
      wr_pend      <= wr_pend + fft_pkg::t_cl_addr'(out_deq_en) +
                      fft_pkg::t_cl_addr'(st_issue) - fft_pkg::t_cl_addr'(wr_rsp_valid);
      case (wr_state)
        fft_pkg::WR_IDLE: begin
          wr_offset <= '0;
          if (hc_control == fft_pkg::HC_CONTROL_START) begin
            wr_state <= fft_pkg::WR_DATA;
          end
        end
        fft_pkg::WR_DATA: begin
          if (out_deq_en) begin
            wr_offset <= wr_offset + 1'b1;
            if ((wr_offset + 1'b1) == num_lines) begin
              wr_state <= fft_pkg::WR_DRAIN;
            end
          end
        end
        // Every data write must be acknowledged before the status line.
        fft_pkg::WR_DRAIN: begin
          if (wr_pend == '0) begin
            wr_state <= fft_pkg::WR_STATUS;
          end
        end
        fft_pkg::WR_STATUS: begin
          if (st_issue) begin
            wr_state <= fft_pkg::WR_DONE;
          end
        end
        default: begin
          if (hc_control != fft_pkg::HC_CONTROL_START) begin
            wr_state <= fft_pkg::WR_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    in_enq_data.raw <= rd_rsp_data;
    if (rd_issue) begin
      rd_req_addr <= src_base + rd_offset;
    end
    if (in_deq_en) begin
      pair_line <= in_head;
    end
    if (out_deq_en) begin
      wr_req_addr <= dst_base + wr_offset;
      wr_req_data <= out_head.raw;
    end else if (st_issue) begin
      wr_req_addr <= dsm_base + 1'b1;
      wr_req_data <= `FFT_LINE_W'(1);
    end
  end

  a_rd_alm_full: assert property (@(posedge clk) disable iff (reset)
    rd_req_alm_full |=> !rd_req_valid);

  a_wr_alm_full: assert property (@(posedge clk) disable iff (reset)
    wr_req_alm_full |=> !wr_req_valid);

  a_rd_bound: assert property (@(posedge clk) disable iff (reset)
    rd_out <= `FFT_FIFO_DEPTH);

endmodule : fft_requestor

/* hdl/fft_accel_top.sv */
// FFT accelerator top level

`timescale 1ns/1ps

`include "fft_defs.svh"

module fft_accel_top (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [31:0]            hc_control,
  input  fft_pkg::t_cl_addr      src_base,
  input  fft_pkg::t_cl_addr      dst_base,
  input  fft_pkg::t_cl_addr      dsm_base,
  input  fft_pkg::t_cl_addr      num_lines,
  output logic                   rd_req_valid,
  output fft_pkg::t_cl_addr      rd_req_addr,
  input  logic                   rd_req_alm_full,
  input  logic                   rd_rsp_valid,
  input  logic [`FFT_LINE_W-1:0] rd_rsp_data,
  output logic                   wr_req_valid,
  output fft_pkg::t_cl_addr      wr_req_addr,
  output logic [`FFT_LINE_W-1:0] wr_req_data,
  input  logic                   wr_req_alm_full,
  input  logic                   wr_rsp_valid
);

  localparam int CNT_W = $clog2(`FFT_FIFO_DEPTH + 1);

  logic             in_enq_en;
  fft_pkg::t_line   in_enq_data;
  fft_pkg::t_line   in_head;
  logic [CNT_W-1:0] in_count;
  logic             in_deq_en;
  logic             pair_start;
  fft_pkg::t_line   pair_line;
  fft_pkg::t_line   bf_line;
  logic             bf_valid;
  fft_pkg::t_line   out_head;
  logic [CNT_W-1:0] out_count;
  logic             out_deq_en;

  fft_requestor req0 (
    .clk             (clk),
    .reset           (reset),
    .hc_control      (hc_control),
    .src_base        (src_base),
    .dst_base        (dst_base),
    .dsm_base        (dsm_base),
    .num_lines       (num_lines),
    .rd_req_valid    (rd_req_valid),
    .rd_req_addr     (rd_req_addr),
    .rd_req_alm_full (rd_req_alm_full),
    .rd_rsp_valid    (rd_rsp_valid),
    .rd_rsp_data     (rd_rsp_data),
    .wr_req_valid    (wr_req_valid),
    .wr_req_addr     (wr_req_addr),
    .wr_req_data     (wr_req_data),
    .wr_req_alm_full (wr_req_alm_full),
    .wr_rsp_valid    (wr_rsp_valid),
    .in_enq_en       (in_enq_en),
    .in_enq_data     (in_enq_data),
    .in_head         (in_head),
    .in_count        (in_count),
    .in_deq_en       (in_deq_en),
    .pair_start      (pair_start),
    .pair_line       (pair_line),
    .out_head        (out_head),
    .out_count       (out_count),
    .out_deq_en      (out_deq_en)
  );

  fft_line_fifo #(
    .DEPTH (`FFT_FIFO_DEPTH)
  ) in_fifo (
    .clk      (clk),
    .reset    (reset),
    .enq_en   (in_enq_en),
    .enq_data (in_enq_data),
    .deq_en   (in_deq_en),
    .deq_data (in_head),
    .count    (in_count)
  );

  // Pair framing pulse is internal to the butterfly.
  fft_butterfly bfly0 (
    .clk        (clk),
    .reset      (reset),
    .pair_start (pair_start),
    .line_in    (pair_line),
    .next_out   (),
    .line_out   (bf_line),
    .line_valid (bf_valid)
  );

  fft_line_fifo #(
    .DEPTH (`FFT_FIFO_DEPTH)
  ) out_fifo (
    .clk      (clk),
    .reset    (reset),
    .enq_en   (bf_valid),
    .enq_data (bf_line),
    .deq_en   (out_deq_en),
    .deq_data (out_head),
    .count    (out_count)
  );

endmodule : fft_accel_top

/* verification/fft_tb_clock.sv */
// Testbench clock and reset

`timescale 1ns/1ps

module fft_tb_clock #(
  parameter int PERIOD       = 10,
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Reset drops on a falling edge, away from the DUT's sampling edge.
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule : fft_tb_clock

/* verification/fft_accel_tb.sv */
// FFT accelerator testbench

`timescale 1ns/1ps

`include "fft_defs.svh"

module fft_accel_tb;

  localparam int CLK_PERIOD  = 10;
  localparam int MAX_LINES   = 32;
  localparam int LINE_BUDGET = 200;
  localparam int TOTAL_LINES = 8 + 20;
  localparam int LIMIT_CYC   = TOTAL_LINES * LINE_BUDGET + 200;

  logic                   clk;
  logic                   reset;
  logic [31:0]            hc_control;
  fft_pkg::t_cl_addr      src_base;
  fft_pkg::t_cl_addr      dst_base;
  fft_pkg::t_cl_addr      dsm_base;
  fft_pkg::t_cl_addr      num_lines;
  logic                   rd_req_valid;
  fft_pkg::t_cl_addr      rd_req_addr;
  logic                   rd_req_alm_full;
  logic                   rd_rsp_valid;
  logic [`FFT_LINE_W-1:0] rd_rsp_data;
  logic                   wr_req_valid;
  fft_pkg::t_cl_addr      wr_req_addr;
  logic [`FFT_LINE_W-1:0] wr_req_data;
  logic                   wr_req_alm_full;
  logic                   wr_rsp_valid;

  fft_pkg::t_line    src_lines [MAX_LINES];
  fft_pkg::t_line    exp_lines [MAX_LINES];
  fft_pkg::t_cl_addr job_src;
  fft_pkg::t_cl_addr job_dst;
  fft_pkg::t_cl_addr job_dsm;
  int                job_lines;
  logic              job_active;

  int   rd_q [$];
  int   ack_owed;
  int   rd_seen;
  int   wr_seen;
  int   acks_seen;
  logic status_seen;
  logic was_active;
  int   line_errs  = 0;
  int   addr_errs  = 0;
  int   proto_errs = 0;

  fft_tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(5)) clk_gen (.clk(clk), .reset(reset));

  fft_accel_top dut0 (
    .clk             (clk),
    .reset           (reset),
    .hc_control      (hc_control),
    .src_base        (src_base),
    .dst_base        (dst_base),
    .dsm_base        (dsm_base),
    .num_lines       (num_lines),
    .rd_req_valid    (rd_req_valid),
    .rd_req_addr     (rd_req_addr),
    .rd_req_alm_full (rd_req_alm_full),
    .rd_rsp_valid    (rd_rsp_valid),
    .rd_rsp_data     (rd_rsp_data),
    .wr_req_valid    (wr_req_valid),
    .wr_req_addr     (wr_req_addr),
    .wr_req_data     (wr_req_data),
    .wr_req_alm_full (wr_req_alm_full),
    .wr_rsp_valid    (wr_rsp_valid)
  );

  // Radix-2 butterfly on one pair. Real and imaginary halves wrap on their own.
  function automatic void fft_ref_pair(input fft_pkg::t_line a, input fft_pkg::t_line b,
                                       output fft_pkg::t_line s_line,
                                       output fft_pkg::t_line d_line);
    logic [15:0] a_part;
    logic [15:0] b_part;
    for (int h = 0; h < 2 * `FFT_SAMPLES; h++) begin
      a_part = a.raw[16*h +: 16];
      b_part = b.raw[16*h +: 16];
      s_line.raw[16*h +: 16] = a_part + b_part;
      d_line.raw[16*h +: 16] = a_part - b_part;
    end
  endfunction

  task automatic check_line(input string name, input fft_pkg::t_line expected,
                            input fft_pkg::t_line actual);
    if (actual.raw !== expected.raw) begin
      line_errs++;
      $display("** Error %s: expected %h, actual %h", name, expected.raw, actual.raw);
    end
  endtask

  task automatic check_addr(input string name, input fft_pkg::t_cl_addr expected,
                            input fft_pkg::t_cl_addr actual);
    if (actual !== expected) begin
      addr_errs++;
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // Host memory with in-order read data, write acks and random almost-full.
  initial begin : host_memory
    int off;
    rd_req_alm_full <= 1'b0;
    wr_req_alm_full <= 1'b0;
    rd_rsp_valid    <= 1'b0;
    rd_rsp_data     <= '0;
    wr_rsp_valid    <= 1'b0;
    ack_owed = 0;
    forever begin
      @(negedge clk);
      if (rd_req_valid) begin
        rd_q.push_back(int'(rd_req_addr - job_src));
      end
      if ((rd_q.size() != 0) && ($urandom % 2 == 0)) begin
        off = rd_q.pop_front();
        rd_rsp_valid <= 1'b1;
        rd_rsp_data  <= (off >= 0 && off < MAX_LINES) ? src_lines[off].raw : '0;
      end else begin
        rd_rsp_valid <= 1'b0;
      end
      if (wr_req_valid) begin
        ack_owed++;
      end
      if ((ack_owed != 0) && ($urandom % 3 == 0)) begin
        ack_owed--;
        wr_rsp_valid <= 1'b1;
      end else begin
        wr_rsp_valid <= 1'b0;
      end
      rd_req_alm_full <= ($urandom % 4 == 0);
      wr_req_alm_full <= ($urandom % 4 == 0);
    end
  end

  always @(negedge clk) begin : compare
    fft_pkg::t_line act;
    fft_pkg::t_line status_line;
    act.raw         = wr_req_data;
    status_line.raw = `FFT_LINE_W'(1);
    if (!job_active && (rd_req_valid || wr_req_valid)) begin
      proto_errs++;
      $display("Request valid while no job was running at %0t", $time);
    end
    if ((rd_req_valid && rd_req_alm_full) || (wr_req_valid && wr_req_alm_full)) begin
      proto_errs++;
      $display("Request valid in the cycle after almost-full at %0t", $time);
    end
    if (job_active && rd_req_valid) begin
      if (rd_seen < job_lines) begin
        check_addr("read_addr", job_src + rd_seen, rd_req_addr);
      end else begin
        proto_errs++;
        $display("Read request beyond the last source line at %0t", $time);
      end
      rd_seen++;
    end
    if (job_active && wr_req_valid) begin
      if (status_seen) begin
        proto_errs++;
        $display("Write request after the status write at %0t", $time);
      end else if (wr_seen < job_lines) begin
        check_addr("write_addr", job_dst + wr_seen, wr_req_addr);
        check_line("write_data", exp_lines[wr_seen], act);
        wr_seen++;
      end else begin
        check_addr("status_addr", job_dsm + 1, wr_req_addr);
        check_line("status_data", status_line, act);
        if (acks_seen != job_lines) begin
          proto_errs++;
          $display("Status write after %0d of %0d write responses", acks_seen, job_lines);
        end
        status_seen = 1'b1;
      end
    end
    if (wr_rsp_valid) begin
      acks_seen++;
    end
    if (was_active && !job_active &&
        (rd_seen != job_lines || wr_seen != job_lines || !status_seen)) begin
      proto_errs++;
      $display("Job of %0d lines ended after %0d reads and %0d writes",
               job_lines, rd_seen, wr_seen);
    end
    if (!job_active) begin
      rd_seen     = 0;
      wr_seen     = 0;
      acks_seen   = 0;
      status_seen = 1'b0;
    end
    was_active = job_active;
  end

  task automatic run_job(input int n, input fft_pkg::t_cl_addr src,
                         input fft_pkg::t_cl_addr dst, input fft_pkg::t_cl_addr dsm);
    for (int i = 0; i < n; i++) begin
      for (int j = 0; j < `FFT_SAMPLES; j++) begin
        src_lines[i].raw[32*j +: 32] = $urandom;
      end
    end
    for (int k = 0; k < n; k += 2) begin
      fft_ref_pair(src_lines[k], src_lines[k+1], exp_lines[k], exp_lines[k+1]);
    end
    job_src   = src;
    job_dst   = dst;
    job_dsm   = dsm;
    job_lines = n;
    @(negedge clk);
    src_base   <= src;
    dst_base   <= dst;
    dsm_base   <= dsm;
    num_lines  <= fft_pkg::t_cl_addr'(n);
    hc_control <= fft_pkg::HC_CONTROL_START;
    job_active <= 1'b1;
    // The status write and every outstanding response mark the end.
    do begin
      @(posedge clk);
    end while (!(status_seen && rd_q.size() == 0 && ack_owed == 0 &&
                 !rd_rsp_valid && !wr_rsp_valid));
    @(negedge clk);
    hc_control <= '0;
    job_active <= 1'b0;
    repeat (4) @(posedge clk);
  endtask

  initial begin : main
    void'($urandom(97));
    hc_control <= '0;
    src_base   <= '0;
    dst_base   <= '0;
    dsm_base   <= '0;
    num_lines  <= '0;
    job_active <= 1'b0;
    job_lines = 0;
    @(negedge reset);
    repeat (10) @(posedge clk);
    run_job(8, 32'h0000_1000, 32'h0000_2000, 32'h0000_3000);
    run_job(20, 32'h0000_4000, 32'h0000_5000, 32'h0000_6000);
    $display("Errors: line %0d, address %0d, protocol %0d", line_errs, addr_errs, proto_errs);
    if (line_errs + addr_errs + proto_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(CLK_PERIOD * LIMIT_CYC);
    $display("Timeout: jobs did not finish within %0d cycles", LIMIT_CYC);
    $display("TB FAILED");
    $finish;
  end

endmodule : fft_accel_tb

/* build.f */
+incdir+include
hdl/fft_pkg.sv
hdl/fft_line_fifo.sv
hdl/fft_butterfly.sv
hdl/fft_requestor.sv
hdl/fft_accel_top.sv
verification/fft_tb_clock.sv
verification/fft_accel_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the log.
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module fft_accel_tb \
  -f build.f -o fft_sim || exit 1
./obj_dir/fft_sim > sim.log 2>&1
grep -q "^TB PASSED$" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
